// ==== all.f ====
+incdir+common
common/rv32i_pkg.sv
decode/regfile.sv
decode/control_rom.sv
decode/hazard_unit.sv
decode/instruction_decode.sv
rtl/decode_top.sv
testbench/decode_chk.sv
testbench/tb_decode.sv

// ==== common/rv32i_cfg.svh ====
`ifndef RV32I_CFG_SVH
`define RV32I_CFG_SVH

// data word width
`define RV_XLEN 32

// architectural register count
`define RV_NREGS 32

// addi x0, x0, 0
`define RV_NOP 32'h0000_0013

// pc value held in ID/EX out of reset
`define RV_RESET_PC 32'h0000_0000

`endif

// ==== common/rv32i_pkg.sv ====
`include "rv32i_cfg.svh"

package rv32i_pkg;

    typedef logic [`RV_XLEN-1:0] rv32i_word;

    typedef enum logic [6:0] {
        op_lui   = 7'b0110111,
        op_auipc = 7'b0010111,
        op_jal   = 7'b1101111,
        op_jalr  = 7'b1100111,
        op_br    = 7'b1100011,
        op_load  = 7'b0000011,
        op_store = 7'b0100011,
        op_imm   = 7'b0010011,
        op_reg   = 7'b0110011
    } rv32i_opcode;

    // funct3 of the op/op-imm groups
    typedef enum logic [2:0] {
        f3_add  = 3'b000,
        f3_sll  = 3'b001,
        f3_slt  = 3'b010,
        f3_sltu = 3'b011,
        f3_xor  = 3'b100,
        f3_sr   = 3'b101,
        f3_or   = 3'b110,
        f3_and  = 3'b111
    } arith_funct3;

    // encoding lines up with funct3 except where funct7[5] picks sub/sra
    typedef enum logic [2:0] {
        alu_add = 3'b000,
        alu_sll = 3'b001,
        alu_sra = 3'b010,
        alu_sub = 3'b011,
        alu_xor = 3'b100,
        alu_srl = 3'b101,
        alu_or  = 3'b110,
        alu_and = 3'b111
    } alu_ops;

    typedef enum logic [2:0] {
        cmp_beq  = 3'b000,
        cmp_bne  = 3'b001,
        cmp_blt  = 3'b100,
        cmp_bge  = 3'b101,
        cmp_bltu = 3'b110,
        cmp_bgeu = 3'b111
    } branch_funct3;

    typedef enum logic {
        alu1_rs1 = 1'b0,
        alu1_pc  = 1'b1
    } alumux1_sel_t;

    typedef enum logic [2:0] {
        alu2_i_imm = 3'd0,
        alu2_u_imm = 3'd1,
        alu2_b_imm = 3'd2,
        alu2_s_imm = 3'd3,
        alu2_j_imm = 3'd4,
        alu2_rs2   = 3'd5
    } alumux2_sel_t;

    typedef enum logic {
        cmp_sel_rs2   = 1'b0,
        cmp_sel_i_imm = 1'b1
    } cmpmux_sel_t;

    // all zero means the instruction has no effect downstream
    typedef struct packed {
        rv32i_opcode  opcode;
        alu_ops       aluop;
        branch_funct3 cmpop;
        logic         load_regfile;
        logic [4:0]   rd;
        logic         mem_read;
        logic         mem_write;
        logic [2:0]   funct3;
        logic         is_branch;
    } rv32i_control_word;

endpackage

// ==== decode/control_rom.sv ====
`timescale 1ns/100ps

module control_rom
    import rv32i_pkg::*;
(
    input  rv32i_word         instr,
    output rv32i_control_word ctrl,
    output alumux1_sel_t      alumux1_sel,
    output alumux2_sel_t      alumux2_sel,
    output cmpmux_sel_t       cmpmux_sel
);

    rv32i_opcode opcode;
    arith_funct3 funct3;
    logic        funct7_5;

    assign opcode   = rv32i_opcode'(instr[6:0]);
    assign funct3   = arith_funct3'(instr[14:12]);
    assign funct7_5 = instr[30];

    always_comb
    begin
        ctrl        = '0;
        alumux1_sel = alu1_rs1;
        alumux2_sel = alu2_i_imm;
        cmpmux_sel  = cmp_sel_rs2;

        case (opcode)
            op_lui, op_auipc, op_jal, op_jalr, op_br,
            op_load, op_store, op_imm, op_reg:
            begin
                ctrl.opcode = opcode;
                ctrl.funct3 = instr[14:12];
                ctrl.aluop  = alu_add;
            end
            default: ;
        endcase

        case (opcode)
            op_lui:
                alumux2_sel = alu2_u_imm;
            op_auipc:
            begin
                alumux1_sel = alu1_pc;
                alumux2_sel = alu2_u_imm;
            end
            op_jal:
            begin
                alumux1_sel    = alu1_pc;
                alumux2_sel    = alu2_j_imm;
                ctrl.is_branch = 1'b1;
            end
            op_jalr:
                ctrl.is_branch = 1'b1;
            op_br:
            begin
                alumux1_sel    = alu1_pc;
                alumux2_sel    = alu2_b_imm;
                ctrl.cmpop     = branch_funct3'(instr[14:12]);
                ctrl.is_branch = 1'b1;
            end
            op_load:
                ctrl.mem_read = 1'b1;
            op_store:
            begin
                alumux2_sel    = alu2_s_imm;
                ctrl.mem_write = 1'b1;
            end
            op_imm, op_reg:
            begin
                if (opcode == op_reg)
                    alumux2_sel = alu2_rs2;
                else
                    cmpmux_sel = cmp_sel_i_imm;
                case (funct3)
                    f3_slt:  ctrl.cmpop = cmp_blt;
                    f3_sltu: ctrl.cmpop = cmp_bltu;
                    f3_sr:   ctrl.aluop = funct7_5 ? alu_sra : alu_srl;
                    // only the register form has sub
                    f3_add:  ctrl.aluop = (funct7_5 && opcode == op_reg) ? alu_sub : alu_add;
                    default: ctrl.aluop = alu_ops'(funct3);
                endcase
            end
            default: ;
        endcase

        // stores and branches write no register
        if (opcode inside {op_lui, op_auipc, op_jal, op_jalr, op_load, op_imm, op_reg})
        begin
            ctrl.load_regfile = 1'b1;
            ctrl.rd           = instr[11:7];
        end
    end

endmodule

// ==== decode/hazard_unit.sv ====
`timescale 1ns/100ps

module hazard_unit
    import rv32i_pkg::*;
(
    input  rv32i_word         instr,
    input  rv32i_control_word id_ex,
    output logic              bubble
);

    logic [4:0] rs1;
    logic [4:0] rs2;
    logic       uses_rs1;
    logic       uses_rs2;

    assign rs1 = instr[19:15];
    assign rs2 = instr[24:20];

    // which source fields the decoding instruction really reads
    always_comb
    begin
        uses_rs1 = 1'b0;
        uses_rs2 = 1'b0;
        case (rv32i_opcode'(instr[6:0]))
            op_jalr, op_load, op_imm:
                uses_rs1 = 1'b1;
            op_store, op_br, op_reg:
            begin
                uses_rs1 = 1'b1;
                uses_rs2 = 1'b1;
            end
            default: ;
        endcase
    end

    assign bubble = id_ex.mem_read && (id_ex.rd != 5'd0) &&
                    ((uses_rs1 && (id_ex.rd == rs1)) || (uses_rs2 && (id_ex.rd == rs2)));

endmodule

// ==== decode/instruction_decode.sv ====
`timescale 1ns/100ps
`include "rv32i_cfg.svh"

module instruction_decode
    import rv32i_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  rv32i_word         pc,
    input  rv32i_word         instr,
    input  logic              ma_stall,
    input  logic              leap,
    input  logic              br_taken,
    // write-back port
    input  rv32i_word         wb_data,
    input  logic [4:0]        wb_rd,
    input  logic              wb_load,
    output rv32i_control_word ctrl_out,
    output rv32i_word         instruction_out,
    output rv32i_word         pc_out,
    output rv32i_word         alu_in1_out,
    output rv32i_word         alu_in2_out,
    output rv32i_word         cmp_in_out,
    output rv32i_word         rs1_out,
    output rv32i_word         rs2_out,
    output logic              bubble
);

    rv32i_word         i_imm;
    rv32i_word         s_imm;
    rv32i_word         b_imm;
    rv32i_word         u_imm;
    rv32i_word         j_imm;
    rv32i_word         reg_a;
    rv32i_word         reg_b;
    rv32i_word         alu_in1;
    rv32i_word         alu_in2;
    rv32i_word         cmp_in;
    rv32i_control_word ctrl;
    alumux1_sel_t      alumux1_sel;
    alumux2_sel_t      alumux2_sel;
    cmpmux_sel_t       cmpmux_sel;

    assign i_imm = {{21{instr[31]}}, instr[30:20]};
    assign s_imm = {{21{instr[31]}}, instr[30:25], instr[11:7]};
    assign b_imm = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
    assign u_imm = {instr[31:12], 12'h000};
    assign j_imm = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

    regfile u_regfile (
        .clk   (clk),
        .rst   (rst),
        .load  (wb_load),
        .in    (wb_data),
        .src_a (instr[19:15]),
        .src_b (instr[24:20]),
        .dest  (wb_rd),
        .reg_a (reg_a),
        .reg_b (reg_b)
    );

    control_rom u_control_rom (
        .instr       (instr),
        .ctrl        (ctrl),
        .alumux1_sel (alumux1_sel),
        .alumux2_sel (alumux2_sel),
        .cmpmux_sel  (cmpmux_sel)
    );

    // compares against the load already sitting in ID/EX
    hazard_unit u_hazard_unit (
        .instr  (instr),
        .id_ex  (ctrl_out),
        .bubble (bubble)
    );

    always_comb
    begin
        alu_in1 = (alumux1_sel == alu1_pc) ? pc : reg_a;

        case (alumux2_sel)
            alu2_i_imm: alu_in2 = i_imm;
            alu2_u_imm: alu_in2 = u_imm;
            alu2_b_imm: alu_in2 = b_imm;
            alu2_s_imm: alu_in2 = s_imm;
            alu2_j_imm: alu_in2 = j_imm;
            alu2_rs2:   alu_in2 = reg_b;
            default:    alu_in2 = i_imm;
        endcase

        cmp_in = (cmpmux_sel == cmp_sel_i_imm) ? i_imm : reg_b;
    end

    // ID/EX register
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            ctrl_out        <= '0;
            instruction_out <= '0;
            pc_out          <= `RV_RESET_PC;
            alu_in1_out     <= '0;
            alu_in2_out     <= '0;
            cmp_in_out      <= '0;
            rs1_out         <= '0;
            rs2_out         <= '0;
        end
        else if (!ma_stall && (br_taken || bubble))
        begin
            // squash into a nop with no side effects
            ctrl_out        <= '0;
            instruction_out <= `RV_NOP;
            pc_out          <= '0;
            alu_in1_out     <= '0;
            alu_in2_out     <= '0;
            cmp_in_out      <= '0;
            rs1_out         <= '0;
            rs2_out         <= '0;
        end
        else if (!ma_stall || leap)
        begin
            ctrl_out        <= ctrl;
            instruction_out <= instr;
            pc_out          <= pc;
            alu_in1_out     <= alu_in1;
            alu_in2_out     <= alu_in2;
            cmp_in_out      <= cmp_in;
            rs1_out         <= reg_a;
            rs2_out         <= reg_b;
        end
    end

endmodule

// ==== decode/regfile.sv ====
`timescale 1ns/100ps
`include "rv32i_cfg.svh"

module regfile
    import rv32i_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       load,
    input  rv32i_word  in,
    input  logic [4:0] src_a,
    input  logic [4:0] src_b,
    input  logic [4:0] dest,
    output rv32i_word  reg_a,
    output rv32i_word  reg_b
);

    rv32i_word data [`RV_NREGS];

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            for (int i = 0; i < `RV_NREGS; i++)
                data[i] <= '0;
        end
        else if (load && (dest != 5'd0))
        begin
            data[dest] <= in;
        end
    end

    // write-through so decode sees the value being written back this cycle
    always_comb
    begin
        if (src_a == 5'd0)
            reg_a = '0;
        else if (load && (dest == src_a))
            reg_a = in;
        else
            reg_a = data[src_a];

        if (src_b == 5'd0)
            reg_b = '0;
        else if (load && (dest == src_b))
            reg_b = in;
        else
            reg_b = data[src_b];
    end

endmodule

// ==== rtl/decode_top.sv ====
`timescale 1ns/100ps

module decode_top
    import rv32i_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    // fetch side
    input  rv32i_word         pc,
    input  rv32i_word         instr,
    // memory access and execute side
    input  logic              ma_stall,
    input  logic              leap,
    input  logic              br_taken,
    // write-back side
    input  rv32i_word         wb_data,
    input  logic [4:0]        wb_rd,
    input  logic              wb_load,
    output rv32i_control_word ctrl_out,
    output rv32i_word         instruction_out,
    output rv32i_word         pc_out,
    output rv32i_word         alu_in1_out,
    output rv32i_word         alu_in2_out,
    output rv32i_word         cmp_in_out,
    output rv32i_word         rs1_out,
    output rv32i_word         rs2_out,
    output logic              bubble
);

    instruction_decode u_instruction_decode (
        .clk             (clk),
        .rst             (rst),
        .pc              (pc),
        .instr           (instr),
        .ma_stall        (ma_stall),
        .leap            (leap),
        .br_taken        (br_taken),
        .wb_data         (wb_data),
        .wb_rd           (wb_rd),
        .wb_load         (wb_load),
        .ctrl_out        (ctrl_out),
        .instruction_out (instruction_out),
        .pc_out          (pc_out),
        .alu_in1_out     (alu_in1_out),
        .alu_in2_out     (alu_in2_out),
        .cmp_in_out      (cmp_in_out),
        .rs1_out         (rs1_out),
        .rs2_out         (rs2_out),
        .bubble          (bubble)
    );

endmodule

// ==== run.sh ====
#!/bin/sh
# compile and run the decode testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -f all.f --top-module tb_decode -Mdir obj_dir

./obj_dir/Vtb_decode > sim.log 2>&1 || true
cat sim.log

if grep -q "sim failed" sim.log; then
    exit 1
fi
grep -q "sim passed" sim.log

// ==== testbench/decode_chk.sv ====
`timescale 1ns/100ps
`include "rv32i_cfg.svh"

module decode_chk
    import rv32i_pkg::*;
(
    input logic              clk,
    input logic              rst,
    input logic              ma_stall,
    input logic              leap,
    input logic              bubble,
    input rv32i_control_word ctrl_out,
    input rv32i_word         instruction_out,
    input rv32i_word         pc_out,
    input rv32i_word         rs1_out
);

    // reset clears the control word
    assert property (@(posedge clk) rst |=> ctrl_out == '0)
        else $error("ctrl_out not zero after reset");

    // load-use hazard turns into a nop
    assert property (@(posedge clk) disable iff (rst)
        (bubble && !ma_stall) |=> instruction_out == `RV_NOP)
        else $error("bubble did not inject a nop");

    assert property (@(posedge clk) disable iff (rst)
        (ma_stall && !leap) |=> $stable(pc_out))
        else $error("pc_out moved during a stall");

    // x0 as source always reads zero
    assert property (@(posedge clk) disable iff (rst)
        (instruction_out[19:15] == 5'd0) |-> rs1_out == '0)
        else $error("rs1_out non-zero for an x0 source");

endmodule

bind instruction_decode decode_chk u_decode_chk (
    .clk             (clk),
    .rst             (rst),
    .ma_stall        (ma_stall),
    .leap            (leap),
    .bubble          (bubble),
    .ctrl_out        (ctrl_out),
    .instruction_out (instruction_out),
    .pc_out          (pc_out),
    .rs1_out         (rs1_out)
);

// ==== testbench/decode_golden.txt ====
# test pc instr stall leap br wb_data wb_rd wb_load | bubble ctrl instr_out pc_out alu1 alu2 cmp rs1 rs2
# hex throughout; outputs are the values after the next edge, bubble is same-cycle; x = don't care
1 00000000 00000013 1 0 0 00000000 00 0 0 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
3 00000010 00000013 0 0 0 00001000 01 1 0 004C0800 00000013 00000010 00000000 00000000 00000000 00000000 00000000
3 00000010 00000013 0 0 0 00000024 02 1 0 004C0800 00000013 00000010 00000000 00000000 00000000 00000000 00000000
3 00000010 00000013 0 0 0 deadbeef 00 1 0 004C0800 00000013 00000010 00000000 00000000 00000000 00000000 00000000
3 00000014 002081B3 0 0 0 00000000 00 0 0 00CC08C0 002081B3 00000014 00001000 00000024 00000024 00001000 00000024
3 00000018 00000233 0 0 0 00000000 00 0 0 00CC0900 00000233 00000018 00000000 00000000 00000000 00000000 00000000
3 0000001c 00038413 0 0 0 cafef00d 07 1 0 004C0A00 00038413 0000001c cafef00d 00000000 00000000 cafef00d 00000000
3 00000020 00038413 0 0 0 00000000 00 0 0 004C0A00 00038413 00000020 cafef00d 00000000 00000000 cafef00d 00000000
2 00000200 12345537 0 0 0 00000000 00 0 0 00DC0A8A 12345537 00000200 x 12345000 x x x
2 00000204 00001597 0 0 0 00000000 00 0 0 005C0AC2 00001597 00000204 00000204 00001000 x x x
2 00000208 008000EF 0 0 0 00000000 00 0 0 01BC0841 008000EF 00000208 00000208 00000008 x x x
2 0000020c 004080E7 0 0 0 00000000 00 0 0 019C0841 004080E7 0000020c 00001000 00000004 x 00001000 x
2 00000210 00208863 0 0 0 00000000 00 0 0 018C0001 00208863 00000210 00000210 00000010 00000024 00001000 00000024
2 00000214 0080A283 0 0 0 00000000 00 0 0 000C0964 0080A283 00000214 00001000 00000008 x 00001000 x
2 00000218 0020A623 0 0 0 00000000 00 0 0 008C0014 0020A623 00000218 00001000 0000000C 00000024 00001000 00000024
2 0000021c FFF08313 0 0 0 00000000 00 0 0 004C0980 FFF08313 0000021c 00001000 FFFFFFFF FFFFFFFF 00001000 00000000
2 00000220 402083B3 0 0 0 00000000 00 0 0 00CD89C0 402083B3 00000220 00001000 00000024 00000024 00001000 00000024
4 00000300 002081B3 0 0 1 00000000 00 0 0 00000000 00000013 00000000 00000000 00000000 00000000 00000000 00000000
4 00000304 402083B3 1 0 1 00000000 00 0 0 00000000 00000013 00000000 00000000 00000000 00000000 00000000 00000000
5 00000400 FFF08313 0 0 0 00000000 00 0 0 004C0980 FFF08313 00000400 00001000 FFFFFFFF FFFFFFFF 00001000 00000000
5 00000404 402083B3 1 0 0 00000000 00 0 0 004C0980 FFF08313 00000400 00001000 FFFFFFFF FFFFFFFF 00001000 00000000
5 00000404 402083B3 1 0 0 00000000 00 0 0 004C0980 FFF08313 00000400 00001000 FFFFFFFF FFFFFFFF 00001000 00000000
5 00000404 402083B3 1 1 0 00000000 00 0 0 00CD89C0 402083B3 00000404 00001000 00000024 00000024 00001000 00000024
6 00000500 0080A283 0 0 0 00000000 00 0 0 000C0964 0080A283 00000500 00001000 00000008 x 00001000 x
6 00000504 002284B3 0 0 0 00000000 00 0 1 00000000 00000013 00000000 00000000 00000000 00000000 00000000 00000000
6 00000508 0080A283 0 0 0 00000000 00 0 0 000C0964 0080A283 00000508 00001000 00000008 x 00001000 x
6 0000050c 002304B3 0 0 0 00000000 00 0 0 00CC0A40 002304B3 0000050c 00000000 00000024 00000024 00000000 00000024
6 00000510 0080A003 0 0 0 00000000 00 0 0 000C0824 0080A003 00000510 00001000 00000008 x 00001000 x
6 00000514 002004B3 0 0 0 00000000 00 0 0 00CC0A40 002004B3 00000514 00000000 00000024 00000024 00000000 00000024

// ==== testbench/tb_decode.sv ====
`timescale 1ns/100ps
`include "rv32i_cfg.svh"

module tb_decode
    import rv32i_pkg::*;
();

    localparam int MAX_VEC = 64;
    localparam int NFIELD  = 9;

    logic              clk;
    logic              rst;
    rv32i_word         pc;
    rv32i_word         instr;
    logic              ma_stall;
    logic              leap;
    logic              br_taken;
    rv32i_word         wb_data;
    logic [4:0]        wb_rd;
    logic              wb_load;
    rv32i_control_word ctrl_out;
    rv32i_word         instruction_out;
    rv32i_word         pc_out;
    rv32i_word         alu_in1_out;
    rv32i_word         alu_in2_out;
    rv32i_word         cmp_in_out;
    rv32i_word         rs1_out;
    rv32i_word         rs2_out;
    logic              bubble;

    // one row per vector with columns as in the golden file
    int          test_no   [MAX_VEC];
    rv32i_word   v_pc      [MAX_VEC];
    rv32i_word   v_instr   [MAX_VEC];
    logic        v_stall   [MAX_VEC];
    logic        v_leap    [MAX_VEC];
    logic        v_br      [MAX_VEC];
    rv32i_word   v_wb_data [MAX_VEC];
    logic [4:0]  v_wb_rd   [MAX_VEC];
    logic        v_wb_load [MAX_VEC];
    logic [31:0] e_val     [MAX_VEC][NFIELD];
    bit          e_care    [MAX_VEC][NFIELD];

    int nvec;
    bit loaded;
    int pass_count;
    int error_count;
    int test_errors;

    decode_top u_decode_top (
        .clk             (clk),
        .rst             (rst),
        .pc              (pc),
        .instr           (instr),
        .ma_stall        (ma_stall),
        .leap            (leap),
        .br_taken        (br_taken),
        .wb_data         (wb_data),
        .wb_rd           (wb_rd),
        .wb_load         (wb_load),
        .ctrl_out        (ctrl_out),
        .instruction_out (instruction_out),
        .pc_out          (pc_out),
        .alu_in1_out     (alu_in1_out),
        .alu_in2_out     (alu_in2_out),
        .cmp_in_out      (cmp_in_out),
        .rs1_out         (rs1_out),
        .rs2_out         (rs2_out),
        .bubble          (bubble)
    );

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic check_word(input string name, input rv32i_word exp, input rv32i_word act);
        if (act !== exp)
        begin
            $display("ERROR %s expected %h got %h", name, exp, act);
            error_count++;
            test_errors++;
        end
        else
            pass_count++;
    endtask

    task automatic check_ctrl(input rv32i_control_word exp, input rv32i_control_word act);
        if (act !== exp)
        begin
            $display("ERROR ctrl_out expected %h got %h", exp, act);
            error_count++;
            test_errors++;
        end
        else
            pass_count++;
    endtask

    task automatic check_bit(input logic exp, input logic act);
        if (act !== exp)
        begin
            $display("ERROR bubble expected %h got %h", exp, act);
            error_count++;
            test_errors++;
        end
        else
            pass_count++;
    endtask

    // "x" marks a don't-care column
    function automatic void parse_field(input string s, output logic [31:0] v, output bit care);
        v = '0;
        care = (s != "x");
        if (care)
            void'($sscanf(s, "%h", v));
    endfunction

    task automatic load_vectors(output bit ok);
        int    fd;
        int    n;
        string line;
        string f [NFIELD];
        logic [31:0] tmp [6];
        ok = 1'b0;
        nvec = 0;
        fd = $fopen("testbench/decode_golden.txt", "r");
        if (fd == 0)
            return;
        while (!$feof(fd) && nvec < MAX_VEC)
        begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() < 2 || line[0] == "#")
                continue;
            n = $sscanf(line, "%d %h %h %h %h %h %h %h %h %s %s %s %s %s %s %s %s %s",
                        test_no[nvec], v_pc[nvec], v_instr[nvec], tmp[0], tmp[1], tmp[2],
                        v_wb_data[nvec], tmp[3], tmp[4],
                        f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8]);
            if (n != 18)
                continue;
            v_stall[nvec]   = tmp[0][0];
            v_leap[nvec]    = tmp[1][0];
            v_br[nvec]      = tmp[2][0];
            v_wb_rd[nvec]   = tmp[3][4:0];
            v_wb_load[nvec] = tmp[4][0];
            for (int k = 0; k < NFIELD; k++)
                parse_field(f[k], e_val[nvec][k], e_care[nvec][k]);
            nvec++;
        end
        $fclose(fd);
        ok = (nvec > 0);
    endtask

    task automatic apply_vector(input int i);
        pc       = v_pc[i];
        instr    = v_instr[i];
        ma_stall = v_stall[i];
        leap     = v_leap[i];
        br_taken = v_br[i];
        wb_data  = v_wb_data[i];
        wb_rd    = v_wb_rd[i];
        wb_load  = v_wb_load[i];
    endtask

    task automatic check_outputs(input int i);
        if (e_care[i][1]) check_ctrl(rv32i_control_word'(e_val[i][1][24:0]), ctrl_out);
        if (e_care[i][2]) check_word("instruction_out", e_val[i][2], instruction_out);
        if (e_care[i][3]) check_word("pc_out", e_val[i][3], pc_out);
        if (e_care[i][4]) check_word("alu_in1_out", e_val[i][4], alu_in1_out);
        if (e_care[i][5]) check_word("alu_in2_out", e_val[i][5], alu_in2_out);
        if (e_care[i][6]) check_word("cmp_in_out", e_val[i][6], cmp_in_out);
        if (e_care[i][7]) check_word("rs1_out", e_val[i][7], rs1_out);
        if (e_care[i][8]) check_word("rs2_out", e_val[i][8], rs2_out);
    endtask

    initial
    begin
        wait (loaded);
        #((nvec + 20) * 4);
        $display("timeout: vectors did not finish in time");
        $display("sim failed");
        $finish;
    end

    initial
    begin
        bit ok;
        rst = 1'b1;
        pc = '0;
        instr = '0;
        ma_stall = 1'b0;
        leap = 1'b0;
        br_taken = 1'b0;
        wb_data = '0;
        wb_rd = '0;
        wb_load = 1'b0;
        pass_count = 0;
        error_count = 0;
        test_errors = 0;
        loaded = 1'b0;
        load_vectors(ok);
        if (!ok)
        begin
            $display("could not open or read the golden vector file");
            $display("sim failed");
        end
        else
        begin
            loaded = 1'b1;
            repeat (3) @(posedge clk);
            #1;
            rst = 1'b0;
            for (int i = 0; i < nvec; i++)
            begin
                apply_vector(i);
                #2;
                if (e_care[i][0])
                    check_bit(e_val[i][0][0], bubble);
                @(posedge clk);
                #0.5;
                check_outputs(i);
                if (i == nvec - 1 || test_no[i + 1] != test_no[i])
                begin
                    $display("test %0d done, %0d errors", test_no[i], test_errors);
                    test_errors = 0;
                end
                #0.5;
            end
            $display("checks passed %0d, errors %0d", pass_count, error_count);
            if (error_count == 0)
                $display("sim passed");
            else
                $display("sim failed");
        end
        $finish;
    end

endmodule
